/* board.f */
+incdir+source
source/board_pkg.sv
source/program_loader.sv
source/scan_timer.sv
source/led_matrix.sv
source/split_memory.sv
source/io_regs.sv
source/board_top.sv
testbench/board_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= board_tb
FILELIST  ?= board.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/board_tb.sv */
`include "board_consts.svh"

module board_tb
  import board_pkg::*;
;

  localparam int CLK_PERIOD   = 100;
  localparam int SCAN_PERIOD  = 20;
  localparam int SCAN_GAP_ON  = 2;
  localparam int SCAN_GAP_OFF = 4;
  localparam int SCAN_FRAMES  = 3;
  localparam int LOAD_WORDS   = 16;
  localparam int SENT_WORDS   = LOAD_WORDS + 8;
  localparam int APB_XFERS    = LOAD_WORDS + 30;
  localparam int TEST_CYCLES  = 3 + SENT_WORDS * 6 + APB_XFERS * 5 + SCAN_FRAMES * 9 * SCAN_PERIOD;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

  logic       sys_clk, rst_n, rx_valid, psel, penable, pwrite;
  logic [7:0] rx_byte;
  addr_t      paddr;
  word_t      pwdata, prdata;
  logic [1:0] pstrb;
  logic       pready, pslverr, tx_valid, run, lcd_e, lcd_rw, lcd_rs;
  logic [7:0] tx_data, led_col;
  logic [8:0] led_row;
  logic [3:0] lcd_db;

  // reference model state, changed on falling edges only
  word_t      mem_model [2**(`BOARD_ADDR_WIDTH-1)];
  logic       exp_run, exp_ready, exp_tx_valid, read_pending;
  logic [7:0] exp_led, exp_lcd, exp_tx_data;
  word_t      exp_rx, exp_rdata, exp_last_data;
  addr_t      exp_last_addr, load_addr;
  logic [31:0] lcg_state;
  int         n_reads, n_errs, n_tx, n_row4, n_row6;

  // scan model, registered like the matrix outputs
  int         m_cnt;
  logic [3:0] m_row;
  logic [8:0] m_led_row;
  logic [7:0] m_led_col;

  board_top #(
    .SCAN_PERIOD  (SCAN_PERIOD),
    .SCAN_GAP_ON  (SCAN_GAP_ON),
    .SCAN_GAP_OFF (SCAN_GAP_OFF)
  ) dut_i (.*);

  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  task automatic abort_run;
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    $display("FAILED at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
    abort_run();
  endtask

  task automatic plain_failure(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    abort_run();
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // random program word, never mistaken for a control word
  function automatic word_t load_word();
    logic [31:0] r;
    word_t       w;
    r = next_random();
    w = r[23:8];
    if (w[15:8] == 8'h7f)
      w[15:8] = 8'h3f;
    return w;
  endfunction

  function automatic word_t expected_read(input addr_t a);
    addr_t w;
    w = {a[`BOARD_ADDR_WIDTH-1:1], 1'b0};
    if (w == `BOARD_IO_LED_ADDR)
      return {exp_lcd, exp_led};
    else if (w == `BOARD_IO_UART_ADDR)
      return exp_rx;
    else if (a[7])
      return 16'h0000;
    return mem_model[a[`BOARD_ADDR_WIDTH-1:1]];
  endfunction

  // hex digit glyph with segment a on top, dot taken from bit 4
  function automatic logic [7:0] digit_glyph(input logic [4:0] n);
    logic [6:0] g;
    case (n[3:0])
      4'h0: g = 7'h7e;
      4'h1: g = 7'h30;
      4'h2: g = 7'h6d;
      4'h3: g = 7'h79;
      4'h4: g = 7'h33;
      4'h5: g = 7'h5b;
      4'h6: g = 7'h5f;
      4'h7: g = 7'h70;
      4'h8: g = 7'h7f;
      4'h9: g = 7'h7b;
      4'ha: g = 7'h77;
      4'hb: g = 7'h1f;
      4'hc: g = 7'h4e;
      4'hd: g = 7'h3d;
      4'he: g = 7'h4f;
      default: g = 7'h47;
    endcase
    return {g, n[4]};
  endfunction

  function automatic logic [7:0] expected_pattern(input logic [3:0] row);
    case (row)
      4'd0: return exp_last_data[15:8];
      4'd1: return exp_last_data[7:0];
      4'd2: return exp_rx[15:8];
      4'd3: return exp_rx[7:0];
      4'd4: return exp_led;
      4'd5: return exp_lcd;
      4'd6: return {7'd0, exp_run};
      4'd7: return exp_last_addr[11:4];
      4'd8: return digit_glyph(exp_last_addr[4:0]);
      default: return 8'd0;
    endcase
  endfunction

  // hi byte, gap, lo byte at edge k, then two edges for the effects
  task automatic send_word(input word_t w);
    logic running;
    running = exp_run;
    @(negedge sys_clk);
    rx_byte  = w[15:8];
    rx_valid = 1'b1;
    @(negedge sys_clk);
    rx_valid = 1'b0;
    @(negedge sys_clk);
    rx_byte  = w[7:0];
    rx_valid = 1'b1;
    @(negedge sys_clk);
    rx_valid = 1'b0;
    @(negedge sys_clk);  // after k+1
    if (!running && w == `BOARD_END_WORD)
      exp_run = 1'b1;
    if (running && w == `BOARD_RELOAD_WORD)
      exp_run = 1'b0;
    @(negedge sys_clk);  // after k+2
    if (running) begin
      exp_rx = w;
      if (w == `BOARD_RELOAD_WORD)
        load_addr = `BOARD_LOAD_BASE;
    end else if (w != `BOARD_END_WORD) begin
      mem_model[load_addr[`BOARD_ADDR_WIDTH-1:1]] = w;
      exp_last_addr = load_addr;
      exp_last_data = w;
      load_addr     = load_addr + 12'd2;
    end
  endtask

  task automatic apb_transfer(input logic wr, input addr_t a, input word_t d,
                              input logic [1:0] s);
    addr_t w;
    w = {a[`BOARD_ADDR_WIDTH-1:1], 1'b0};
    @(negedge sys_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    pstrb   = s;
    @(negedge sys_clk);
    penable   = 1'b1;
    exp_ready = !exp_run || wr;  // reads wait one cycle while running
    if (!exp_run)
      n_errs++;
    if (!exp_ready) begin
      @(negedge sys_clk);
      exp_ready = 1'b1;
    end
    @(negedge sys_clk);
    psel         = 1'b0;
    penable      = 1'b0;
    read_pending = 1'b0;
    if (wr && exp_run) begin
      if (w == `BOARD_IO_LED_ADDR) begin
        if (s[0])
          exp_led = d[7:0];
        if (s[1])
          exp_lcd = d[15:8];
      end else if (w == `BOARD_IO_UART_ADDR) begin
        exp_tx_data  = d[7:0];
        exp_tx_valid = 1'b1;
        n_tx++;
      end else if (!a[7]) begin
        if (s[1])
          mem_model[a[`BOARD_ADDR_WIDTH-1:1]][15:8] = d[15:8];
        if (s[0])
          mem_model[a[`BOARD_ADDR_WIDTH-1:1]][7:0] = d[7:0];
        if (s != 2'b00) begin
          exp_last_addr = a;
          exp_last_data = d;
        end
      end
    end
    @(negedge sys_clk);
    exp_tx_valid = 1'b0;
  endtask

  task automatic read_check(input addr_t a);
    exp_rdata    = expected_read(a);
    read_pending = 1'b1;
    n_reads++;
    apb_transfer(1'b0, a, 16'h0000, 2'b00);
  endtask

  always @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_cnt     <= 0;
      m_row     <= 4'd0;
      m_led_row <= 9'd0;
      m_led_col <= 8'd0;
    end else begin
      m_cnt <= (m_cnt == SCAN_PERIOD - 1) ? 0 : m_cnt + 1;
      if (m_cnt == 0)
        m_row <= (m_row == 4'd8) ? 4'd0 : m_row + 4'd1;
      m_led_row <= (m_cnt >= SCAN_GAP_ON && m_cnt < SCAN_PERIOD - SCAN_GAP_OFF) ?
                   (9'd1 << m_row) : 9'd0;
      m_led_col <= expected_pattern(m_row);
    end
  end

  always @(negedge sys_clk) begin
    if (led_row[4])
      n_row4++;
    if (led_row[6])
      n_row6++;
  end

  a_reset_idle: assert property (@(posedge sys_clk)
    !rst_n |-> (!run && !tx_valid && led_row == 9'd0 && !pready && !pslverr))
    else plain_failure("outputs not idle while reset is asserted");
  a_run: assert property (@(posedge sys_clk) disable iff (!rst_n) run == exp_run)
    else value_mismatch("run", 32'($sampled(run)), 32'(exp_run));
  a_ready: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (psel && penable) |-> pready == exp_ready)
    else value_mismatch("pready", 32'($sampled(pready)), 32'(exp_ready));
  a_slverr: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (psel && penable) |-> pslverr == !exp_run)
    else value_mismatch("pslverr", 32'($sampled(pslverr)), 32'(!exp_run));
  a_rdata: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (psel && penable && pready && !pwrite && read_pending) |-> prdata == exp_rdata)
    else value_mismatch("prdata", 32'($sampled(prdata)), 32'(exp_rdata));
  a_tx_valid: assert property (@(posedge sys_clk) disable iff (!rst_n) tx_valid == exp_tx_valid)
    else value_mismatch("tx_valid", 32'($sampled(tx_valid)), 32'(exp_tx_valid));
  a_tx_data: assert property (@(posedge sys_clk) disable iff (!rst_n) tx_data == exp_tx_data)
    else value_mismatch("tx_data", 32'($sampled(tx_data)), 32'(exp_tx_data));
  a_lcd: assert property (@(posedge sys_clk) disable iff (!rst_n)
    {lcd_db, lcd_rs, lcd_rw, lcd_e} == {exp_lcd[7:4], exp_lcd[2:0]})
    else value_mismatch("lcd pins", 32'($sampled({lcd_db, lcd_rs, lcd_rw, lcd_e})),
                        32'({exp_lcd[7:4], exp_lcd[2:0]}));
  a_row_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n) $onehot0(led_row))
    else plain_failure("led_row drives more than one row");
  a_row: assert property (@(posedge sys_clk) disable iff (!rst_n) led_row == m_led_row)
    else value_mismatch("led_row", 32'($sampled(led_row)), 32'(m_led_row));
  a_col: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (led_row != 9'd0) |-> led_col == m_led_col)
    else value_mismatch("led_col", 32'($sampled(led_col)), 32'(m_led_col));

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    plain_failure("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    sys_clk       = 1'b0;
    rst_n         = 1'b0;
    rx_byte       = 8'h00;
    rx_valid      = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    pstrb         = 2'b00;
    lcg_state     = 32'd35;
    exp_run       = 1'b0;
    exp_ready     = 1'b0;
    exp_tx_valid  = 1'b0;
    read_pending  = 1'b0;
    exp_led       = 8'h00;
    exp_lcd       = 8'h00;
    exp_tx_data   = 8'h00;
    exp_rx        = '0;
    exp_rdata     = '0;
    exp_last_data = '0;
    exp_last_addr = '0;
    load_addr     = `BOARD_LOAD_BASE;
    n_reads       = 0;
    n_errs        = 0;
    n_tx          = 0;
    n_row4        = 0;
    n_row6        = 0;
    repeat (3) @(negedge sys_clk);
    rst_n = 1'b1;

    // bus locked out while loading
    apb_transfer(1'b1, 12'h310, 16'hdead, 2'b11);
    apb_transfer(1'b0, 12'h310, 16'h0000, 2'b00);

    for (int i = 0; i < LOAD_WORDS; i++)
      send_word(load_word());
    send_word(`BOARD_END_WORD);
    for (int i = 0; i < LOAD_WORDS; i++)
      read_check(`BOARD_LOAD_BASE + 12'(2 * i));
    read_check(`BOARD_LOAD_BASE + 12'd1);  // bit 0 ignored

    // byte lane merges
    apb_transfer(1'b1, 12'h400, 16'h1234, 2'b11);
    apb_transfer(1'b1, 12'h400, 16'habcd, 2'b10);
    apb_transfer(1'b1, 12'h400, 16'h5566, 2'b01);
    apb_transfer(1'b1, 12'h400, 16'hffff, 2'b00);
    read_check(12'h400);
    read_check(12'h0c0);
    read_check(12'h084);
    read_check(12'h1fe);
    apb_transfer(1'b1, 12'h0c0, 16'hbeef, 2'b11);
    read_check(12'h0c0);

    // io registers and transmit
    apb_transfer(1'b1, `BOARD_IO_LED_ADDR, 16'hf0a5, 2'b11);
    read_check(`BOARD_IO_LED_ADDR);
    apb_transfer(1'b1, `BOARD_IO_LED_ADDR, 16'h3c00, 2'b10);
    apb_transfer(1'b1, `BOARD_IO_LED_ADDR, 16'h005a, 2'b01);
    read_check(`BOARD_IO_LED_ADDR + 12'd1);
    apb_transfer(1'b1, `BOARD_IO_UART_ADDR, 16'h0041, 2'b11);
    apb_transfer(1'b1, `BOARD_IO_UART_ADDR, 16'h1242, 2'b01);

    // received words, then reload and a fresh image
    send_word(16'h1357);
    read_check(`BOARD_IO_UART_ADDR);
    send_word(16'h2468);
    read_check(`BOARD_IO_UART_ADDR);
    send_word(`BOARD_RELOAD_WORD);
    apb_transfer(1'b0, `BOARD_IO_UART_ADDR, 16'h0000, 2'b00);
    for (int i = 0; i < 3; i++)
      send_word(load_word());
    send_word(`BOARD_END_WORD);
    for (int i = 0; i < 3; i++)
      read_check(`BOARD_LOAD_BASE + 12'(2 * i));
    read_check(`BOARD_IO_UART_ADDR);

    // odd digit with the dot on the 7-segment row
    apb_transfer(1'b1, 12'h417, 16'h9c3e, 2'b11);

    // let the matrix scan a few frames
    apb_transfer(1'b1, `BOARD_IO_LED_ADDR, 16'h00c3, 2'b01);
    repeat (SCAN_FRAMES * 9 * SCAN_PERIOD) @(negedge sys_clk);

    if (n_reads == 0 || n_errs == 0 || n_tx == 0 || n_row4 == 0 || n_row6 == 0) begin
      plain_failure("some checks were never reached by the stimulus");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

/* source/board_top.sv */
`include "board_consts.svh"

module board_top
  import board_pkg::*;
#(
  parameter int SCAN_PERIOD  = `BOARD_SCAN_PERIOD,
  parameter int SCAN_GAP_ON  = `BOARD_SCAN_GAP_ON,
  parameter int SCAN_GAP_OFF = `BOARD_SCAN_GAP_OFF
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  addr_t      paddr,
  input  word_t      pwdata,
  input  logic [1:0] pstrb,
  output word_t      prdata,
  output logic       pready,
  output logic       pslverr,
  output logic [7:0] tx_data,
  output logic       tx_valid,
  output logic       run,
  output logic [7:0] led_col,
  output logic [8:0] led_row,
  output logic       lcd_e,
  output logic       lcd_rw,
  output logic       lcd_rs,
  output logic [3:0] lcd_db
);

  mem_req_t   load_req;
  mem_req_t   bus_req;
  word_t      rx_word;
  logic       rx_word_valid;
  word_t      rd_data;
  mem_last_t  mem_last;
  io_state_t  io_state;
  logic [3:0] row_index;
  logic       lit;

  program_loader loader_i (.*);

  scan_timer #(
    .PERIOD  (SCAN_PERIOD),
    .GAP_ON  (SCAN_GAP_ON),
    .GAP_OFF (SCAN_GAP_OFF)
  ) scan_i (.*);

  led_matrix matrix_i (.*);

  split_memory mem_i (.*);

  io_regs io_i (.*);

  // lcd nibble port lives in the upper byte of the led word
  assign lcd_e  = io_state.lcd[0];
  assign lcd_rw = io_state.lcd[1];
  assign lcd_rs = io_state.lcd[2];
  assign lcd_db = io_state.lcd[7:4];

endmodule

/* source/io_regs.sv */
`include "board_consts.svh"

module io_regs
  import board_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  addr_t      paddr,
  input  word_t      pwdata,
  input  logic [1:0] pstrb,
  input  logic       run,
  input  word_t      rx_word,
  input  logic       rx_word_valid,
  input  word_t      rd_data,
  output word_t      prdata,
  output logic       pready,
  output logic       pslverr,
  output mem_req_t   bus_req,
  output io_state_t  io_state,
  output logic [7:0] tx_data,
  output logic       tx_valid
);

  logic       access;     // apb access phase
  logic       wait_done;  // read wait state already spent
  addr_t      word_addr;
  logic       is_led;
  logic       is_uart;
  logic       is_hole;    // io space with nothing behind it
  logic       wr_fire;
  logic [7:0] led_q;
  logic [7:0] lcd_q;
  word_t      rx_q;

  assign access    = psel && penable;
  assign word_addr = {paddr[`BOARD_ADDR_WIDTH-1:1], 1'b0};
  assign is_led    = word_addr == `BOARD_IO_LED_ADDR;
  assign is_uart   = word_addr == `BOARD_IO_UART_ADDR;
  assign is_hole   = paddr[7] && !is_led && !is_uart;

  // writes finish at once, reads wait one cycle for the memory
  assign pready  = access && (!run || pwrite || wait_done);
  assign pslverr = access && !run;
  assign wr_fire = access && pwrite && run;

  assign bus_req = '{
    valid:   access && run && !paddr[7] && (pwrite || !wait_done),
    addr:    paddr,
    byte_en: pwrite ? pstrb : 2'b00,
    wdata:   pwdata
  };

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      wait_done <= 1'b0;
    else
      wait_done <= access && !pwrite && run && !wait_done;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      led_q    <= 8'd0;
      lcd_q    <= 8'd0;
      tx_data  <= 8'd0;
      tx_valid <= 1'b0;
      rx_q     <= '0;
    end else begin
      tx_valid <= wr_fire && is_uart;  // single cycle strobe
      if (wr_fire && is_led && pstrb[0])
        led_q <= pwdata[7:0];
      if (wr_fire && is_led && pstrb[1])
        lcd_q <= pwdata[15:8];
      if (wr_fire && is_uart)
        tx_data <= pwdata[7:0];
      if (rx_word_valid)
        rx_q <= rx_word;
    end
  end

  always_comb begin
    if (is_led)
      prdata = {lcd_q, led_q};
    else if (is_uart)
      prdata = rx_q;
    else if (is_hole)
      prdata = '0;
    else
      prdata = rd_data;
  end

  assign io_state = '{led: led_q, lcd: lcd_q, rx_word: rx_q};

  a_penable_psel: assert property (@(posedge sys_clk) disable iff (!rst_n)
    penable |-> psel);

endmodule

/* source/split_memory.sv */
`include "board_consts.svh"

module split_memory
  import board_pkg::*;
(
  input  logic      sys_clk,
  input  logic      rst_n,
  input  mem_req_t  load_req,
  input  mem_req_t  bus_req,
  output word_t     rd_data,
  output mem_last_t mem_last
);

  localparam int IDX_W = `BOARD_ADDR_WIDTH - 1;
  localparam int DEPTH = 2 ** IDX_W;

  logic [7:0] bank_even [DEPTH];  // bits 15:8
  logic [7:0] bank_odd  [DEPTH];  // bits 7:0

  mem_req_t   req;
  logic [IDX_W-1:0] idx;
  logic       wr_any;

  // loader wins, it cannot wait
  assign req    = load_req.valid ? load_req : bus_req;
  assign idx    = req.addr[`BOARD_ADDR_WIDTH-1:1];
  assign wr_any = req.valid && (req.byte_en != 2'b00);

  always_ff @(posedge sys_clk) begin
    if (req.valid && req.byte_en[1])
      bank_even[idx] <= req.wdata[15:8];
    if (req.valid && req.byte_en[0])
      bank_odd[idx] <= req.wdata[7:0];
    if (req.valid)
      rd_data <= {bank_even[idx], bank_odd[idx]};  // old data on a write
  end

  // shown on the led matrix
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      mem_last <= '0;
    else if (wr_any)
      mem_last <= '{addr: req.addr, wdata: req.wdata};
  end

  // bus requests only come while running, loads only while loading
  a_no_collision: assert property (@(posedge sys_clk) disable iff (!rst_n)
    !(load_req.valid && bus_req.valid));

endmodule

/* source/led_matrix.sv */
module led_matrix
  import board_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic [3:0] row_index,
  input  logic       lit,
  input  mem_last_t  mem_last,
  input  io_state_t  io_state,
  input  logic       run,
  output logic [7:0] led_col,
  output logic [8:0] led_row
);

  logic [7:0] pattern;

  // segments a..g in bits 7..1, dot in bit 0
  function automatic logic [7:0] seg7(input logic [4:0] n);
    logic [6:0] segs;
    case (n[3:0])
      4'h0: segs = 7'b1111110;
      4'h1: segs = 7'b0110000;
      4'h2: segs = 7'b1101101;
      4'h3: segs = 7'b1111001;
      4'h4: segs = 7'b0110011;
      4'h5: segs = 7'b1011011;
      4'h6: segs = 7'b1011111;
      4'h7: segs = 7'b1110000;
      4'h8: segs = 7'b1111111;
      4'h9: segs = 7'b1111011;
      4'ha: segs = 7'b1110111;
      4'hb: segs = 7'b0011111;
      4'hc: segs = 7'b1001110;
      4'hd: segs = 7'b0111101;
      4'he: segs = 7'b1001111;
      default: segs = 7'b1000111;  // f
    endcase
    return {segs, n[4]};
  endfunction

  always_comb begin
    case (row_index)
      4'd0: pattern = mem_last.wdata[15:8];
      4'd1: pattern = mem_last.wdata[7:0];
      4'd2: pattern = io_state.rx_word[15:8];
      4'd3: pattern = io_state.rx_word[7:0];
      4'd4: pattern = io_state.led;
      4'd5: pattern = io_state.lcd;
      4'd6: pattern = {7'd0, run};
      4'd7: pattern = mem_last.addr[11:4];
      4'd8: pattern = seg7(mem_last.addr[4:0]);
      default: pattern = 8'd0;
    endcase
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      led_col <= 8'd0;
      led_row <= 9'd0;
    end else begin
      led_col <= pattern;
      led_row <= lit ? (9'd1 << row_index) : 9'd0;  // one row at a time
    end
  end

endmodule

/* source/scan_timer.sv */
`include "board_consts.svh"

module scan_timer #(
  parameter int PERIOD  = `BOARD_SCAN_PERIOD,
  parameter int GAP_ON  = `BOARD_SCAN_GAP_ON,
  parameter int GAP_OFF = `BOARD_SCAN_GAP_OFF
) (
  input  logic       sys_clk,
  input  logic       rst_n,
  output logic [3:0] row_index,
  output logic       lit
);

  localparam int CNT_W = $clog2(PERIOD);

  logic [CNT_W-1:0] counter;

  // one full row time per wrap
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n)
      counter <= '0;
    else if (counter == CNT_W'(PERIOD - 1))
      counter <= '0;
    else
      counter <= counter + 1'b1;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      row_index <= 4'd0;
    end else if (counter == '0) begin
      if (row_index < 4'd8)
        row_index <= row_index + 4'd1;
      else
        row_index <= 4'd0;  // nine rows
    end
  end

  // dark at both ends of the row time so neighbours do not ghost
  assign lit = (int'(counter) >= GAP_ON) && (int'(counter) < PERIOD - GAP_OFF);

  a_row_range: assert property (@(posedge sys_clk) disable iff (!rst_n)
    row_index <= 4'd8);

endmodule

/* source/program_loader.sv */
`include "board_consts.svh"

module program_loader
  import board_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_valid,
  output mem_req_t   load_req,
  output logic       run,
  output word_t      rx_word,
  output logic       rx_word_valid
);

  // hi/lo tracks which byte of the pair comes next
  typedef enum logic [1:0] {
    LOAD_HI,
    LOAD_LO,
    RUN_HI,
    RUN_LO
  } ld_state_t;

  ld_state_t  state;
  logic [7:0] hi_byte;
  word_t      word_q;     // assembled pair
  logic       word_done;  // word_q is new this cycle
  logic       load_valid;
  addr_t      load_addr;
  logic       lo_strobe;
  logic       is_end;
  logic       is_reload;

  assign lo_strobe = rx_valid && (state == LOAD_LO || state == RUN_LO);
  assign is_end    = word_done && state == LOAD_HI && word_q == `BOARD_END_WORD;
  assign is_reload = word_done && state == RUN_HI && word_q == `BOARD_RELOAD_WORD;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= LOAD_HI;
    end else begin
      case (state)
        LOAD_HI: begin
          if (is_end)
            state <= RUN_HI;
          else if (rx_valid)
            state <= LOAD_LO;
        end
        LOAD_LO: if (rx_valid) state <= LOAD_HI;
        RUN_HI: begin
          if (is_reload)
            state <= LOAD_HI;
          else if (rx_valid)
            state <= RUN_LO;
        end
        default: if (rx_valid) state <= RUN_HI;
      endcase
    end
  end

  // byte pair assembly, high byte first
  always_ff @(posedge sys_clk) begin
    if (rx_valid && !lo_strobe)
      hi_byte <= rx_byte;
    if (lo_strobe)
      word_q <= {hi_byte, rx_byte};
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      word_done     <= 1'b0;
      load_valid    <= 1'b0;
      rx_word_valid <= 1'b0;
      load_addr     <= `BOARD_LOAD_BASE;
    end else begin
      word_done     <= lo_strobe;
      load_valid    <= word_done && state == LOAD_HI && !is_end;
      rx_word_valid <= word_done && state == RUN_HI;
      if (is_reload)
        load_addr <= `BOARD_LOAD_BASE;
      else if (load_valid)
        load_addr <= load_addr + 2'd2;  // step after the write
    end
  end

  assign run      = (state == RUN_HI) || (state == RUN_LO);
  assign rx_word  = word_q;
  assign load_req = '{valid: load_valid, addr: load_addr, byte_en: 2'b11, wdata: word_q};

  // pair assembly relies on a gap between byte strobes
  a_rx_spacing: assert property (@(posedge sys_clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid);

endmodule

/* source/board_pkg.sv */
`include "board_consts.svh"

package board_pkg;

  // byte address
  typedef logic [`BOARD_ADDR_WIDTH-1:0] addr_t;

  typedef logic [15:0] word_t;

  // one memory access; byte_en[1] is the even (high) byte
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    logic [1:0] byte_en;  // all zero for a read
    word_t      wdata;
  } mem_req_t;

  // last write seen by the memory, for the display
  typedef struct packed {
    addr_t addr;
    word_t wdata;
  } mem_last_t;

  // io register state shown on the matrix
  typedef struct packed {
    logic [7:0] led;
    logic [7:0] lcd;
    word_t      rx_word;
  } io_state_t;

endpackage

/* source/board_consts.svh */
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// byte address width of the whole board
`define BOARD_ADDR_WIDTH 12

// program image lands here
`define BOARD_LOAD_BASE 12'h300

// memory-mapped io words
`define BOARD_IO_LED_ADDR  12'h080 // hi byte lcd, lo byte led
`define BOARD_IO_UART_ADDR 12'h082

// loader control words
`define BOARD_END_WORD    16'h7fff // stops the load
`define BOARD_RELOAD_WORD 16'h7ffe // back to loading while running

// led matrix scan, in sys_clk cycles
`define BOARD_SCAN_PERIOD  27000
`define BOARD_SCAN_GAP_ON  100
`define BOARD_SCAN_GAP_OFF 2000

`endif
